// File: pdp_pkg.sv
package pdp_pkg;

   // ======================================================================
   // widths and basic types
   // ======================================================================

   localparam int WORD_W = 16;
   localparam int BYTE_W = 8;

   typedef logic [WORD_W-1:0] word_t;

   // condition codes, msb to lsb
   typedef logic [3:0] cc_t;

   localparam int CC_N = 3;
   localparam int CC_Z = 2;
   localparam int CC_V = 1;
   localparam int CC_C = 0;

   // ======================================================================
   // alu opcodes
   // ======================================================================

   // adder ops sit in one contiguous range, logic and shift ops after it
   typedef enum logic [4:0] {
      OP_NOP  = 5'd0,
      OP_ADD  = 5'd1,
      OP_ADC  = 5'd2,
      OP_SUB  = 5'd3,
      OP_SBC  = 5'd4,
      OP_INC  = 5'd5,
      OP_DEC  = 5'd6,
      OP_INC2 = 5'd7,
      OP_DEC2 = 5'd8,
      OP_NEG  = 5'd9,
      OP_CMP  = 5'd10,
      OP_CLR  = 5'd11,
      OP_COM  = 5'd12,
      OP_TST  = 5'd13,
      OP_ROR  = 5'd14,
      OP_ROL  = 5'd15,
      OP_ASR  = 5'd16,
      OP_ASL  = 5'd17,
      OP_SXT  = 5'd18,
      OP_MOV  = 5'd19,
      OP_BIT  = 5'd20,
      OP_BIC  = 5'd21,
      OP_BIS  = 5'd22,
      OP_EXOR = 5'd23,
      OP_SWAB = 5'd24
   } alu_op_e;

endpackage

// File: alu_ctl_if.sv
`timescale 1ns/1ps

interface alu_ctl_if;
   import pdp_pkg::*;

   alu_op_e op;
   logic    byte_mode;
   word_t   src;
   word_t   dst;
   logic    ci;        // carry fed back from the cc register
   logic    ni;        // negative fed back, used by sxt

   modport exec (
      output op, byte_mode, src, dst, ci, ni
   );

   modport alu (
      input op, byte_mode, src, dst, ci, ni
   );

endinterface

// File: alu_adder.sv
`timescale 1ns/1ps

module alu_adder #(
   parameter int WIDTH = pdp_pkg::WORD_W
) (
   input  logic [WIDTH-1:0] a,
   input  logic [WIDTH-1:0] b,
   input  logic             ci,
   output logic [WIDTH-1:0] sum,
   output logic             co,
   output logic             vo
);

   logic             c_msb;   // carry into the top bit
   logic [WIDTH-2:0] low_sum;
   logic             top_sum;

   assign {c_msb, low_sum} = {1'b0, a[WIDTH-2:0]} + {1'b0, b[WIDTH-2:0]}
                           + {{(WIDTH-1){1'b0}}, ci};

   assign {co, top_sum} = {1'b0, a[WIDTH-1]} + {1'b0, b[WIDTH-1]} + {1'b0, c_msb};

   assign sum = {top_sum, low_sum};
   assign vo  = c_msb ^ co;   // signed overflow

endmodule

// File: lsi_alu.sv
`timescale 1ns/1ps

module lsi_alu (
   alu_ctl_if.alu         ctl,
   output pdp_pkg::word_t result,
   output pdp_pkg::cc_t   flags,
   output pdp_pkg::cc_t   wmask
);
   import pdp_pkg::*;

   word_t             s;
   word_t             d;

   // adder path
   word_t             x;
   word_t             y;
   logic              a_ci;
   logic              c_inv;    // borrow style carry
   logic              c_clr;
   logic              a_byte;
   word_t             sum16;
   logic [BYTE_W-1:0] sum8;
   logic              co16;
   logic              vo16;
   logic              co8;
   logic              vo8;
   logic              a_n;
   logic              a_z;
   logic              a_v;
   logic              a_c;
   cc_t               add_flags;
   logic              use_adder;

   // logic and shift path
   word_t             lg_res;
   word_t             nz_word;  // word that N and Z are taken from
   logic              nz_byte;
   logic              nz_from_res;
   logic              is_shift;
   logic              lg_n;
   logic              lg_z;
   logic              lg_v;
   logic              lg_c;
   cc_t               lg_flags;

   cc_t               ccmask;
   logic              touches_cc;

   function automatic cc_t mk_cc(input logic n, input logic z, input logic v, input logic c);
      cc_t f;
      f       = '0;
      f[CC_N] = n;
      f[CC_Z] = z;
      f[CC_V] = v;
      f[CC_C] = c;
      return f;
   endfunction

   assign s = ctl.src;
   assign d = ctl.dst;

   // ======================================================================
   // shared adders
   // ======================================================================

   alu_adder #(.WIDTH(WORD_W)) u_add16 (
      .a   (x),
      .b   (y),
      .ci  (a_ci),
      .sum (sum16),
      .co  (co16),
      .vo  (vo16)
   );

   alu_adder #(.WIDTH(BYTE_W)) u_add8 (
      .a   (x[BYTE_W-1:0]),
      .b   (y[BYTE_W-1:0]),
      .ci  (a_ci),
      .sum (sum8),
      .co  (co8),
      .vo  (vo8)
   );

   always_comb begin
      x      = '0;
      y      = '0;
      a_ci   = 1'b0;
      c_inv  = 1'b0;
      c_clr  = 1'b0;
      a_byte = 1'b0;
      case (ctl.op)
         OP_ADD: begin
            x = s;
            y = d;
         end
         OP_ADC: begin
            y      = d;
            a_ci   = ctl.ci;
            a_byte = ctl.byte_mode;
         end
         OP_SUB: begin
            x     = ~s;
            y     = d;
            a_ci  = 1'b1;
            c_inv = 1'b1;
         end
         OP_SBC: begin
            x      = '1;
            y      = d;
            a_ci   = ~ctl.ci;
            c_inv  = 1'b1;
            a_byte = ctl.byte_mode;
         end
         OP_INC: begin
            y      = d;
            a_ci   = 1'b1;
            c_clr  = 1'b1;
            a_byte = ctl.byte_mode;
         end
         OP_DEC: begin
            x      = '1;
            y      = d;
            c_clr  = 1'b1;
            a_byte = ctl.byte_mode;
         end
         OP_INC2: begin
            x = 16'h0002;
            y = d;
         end
         OP_DEC2: begin
            x = d;
            y = 16'hfffe;
         end
         OP_NEG: begin
            y      = ~d;
            a_ci   = 1'b1;
            c_inv  = 1'b1;
            a_byte = ctl.byte_mode;
         end
         OP_CMP: begin
            x      = ~s;
            y      = d;
            a_ci   = 1'b1;
            c_inv  = 1'b1;
            a_byte = ctl.byte_mode;
         end
         default: ;
      endcase
   end

   assign a_n = a_byte ? sum8[BYTE_W-1] : sum16[WORD_W-1];
   assign a_z = a_byte ? (sum8 == '0) : (sum16 == '0);
   assign a_v = a_byte ? vo8 : vo16;
   assign a_c = c_clr ? 1'b0 : ((a_byte ? co8 : co16) ^ c_inv);

   assign add_flags = mk_cc(a_n, a_z, a_v, a_c);

   // ======================================================================
   // logic and shift ops
   // ======================================================================

   always_comb begin
      lg_res      = '0;
      nz_word     = '0;
      nz_byte     = ctl.byte_mode;
      nz_from_res = 1'b1;
      is_shift    = 1'b0;
      lg_c        = 1'b0;
      case (ctl.op)
         OP_CLR: lg_res = '0;
         OP_COM: begin
            lg_res = ~d;
            lg_c   = 1'b1;
         end
         OP_TST: begin
            nz_word     = d;
            nz_from_res = 1'b0;
         end
         OP_ROR: begin
            is_shift = 1'b1;
            lg_c     = d[0];
            if (ctl.byte_mode) lg_res = {{BYTE_W{1'b0}}, ctl.ci, d[7:1]};
            else               lg_res = {ctl.ci, d[15:1]};
         end
         OP_ROL: begin
            is_shift = 1'b1;
            lg_c     = ctl.byte_mode ? d[7] : d[15];
            if (ctl.byte_mode) lg_res = {{BYTE_W{1'b0}}, d[6:0], ctl.ci};
            else               lg_res = {d[14:0], ctl.ci};
         end
         OP_ASR: begin
            is_shift = 1'b1;
            lg_c     = d[0];
            if (ctl.byte_mode) lg_res = {{BYTE_W{1'b0}}, d[7], d[7:1]};
            else               lg_res = {d[15], d[15:1]};
         end
         OP_ASL: begin
            is_shift = 1'b1;
            lg_c     = ctl.byte_mode ? d[7] : d[15];
            if (ctl.byte_mode) lg_res = {{BYTE_W{1'b0}}, d[6:0], 1'b0};
            else               lg_res = {d[14:0], 1'b0};
         end
         OP_SXT: lg_res = ctl.ni ? '1 : '0;
         OP_MOV: lg_res = ctl.byte_mode ? {{BYTE_W{d[7]}}, d[7:0]} : d;
         OP_BIT: begin
            nz_word     = s & d;
            nz_from_res = 1'b0;
         end
         OP_BIC:  lg_res = s & ~d;
         OP_BIS:  lg_res = s | d;
         OP_EXOR: begin
            lg_res  = s ^ d;
            nz_byte = 1'b0;            // always word flags
         end
         OP_SWAB: begin
            lg_res  = {d[7:0], d[15:8]};
            nz_byte = 1'b1;            // flags from new low byte
         end
         default: ;
      endcase

      if (nz_from_res) nz_word = lg_res;
      lg_n = nz_byte ? nz_word[BYTE_W-1] : nz_word[WORD_W-1];
      lg_z = nz_byte ? (nz_word[BYTE_W-1:0] == '0) : (nz_word == '0);
      if (ctl.op == OP_SXT) lg_n = 1'b0;
      lg_v     = is_shift ? (lg_n ^ lg_c) : 1'b0;
      lg_flags = mk_cc(lg_n, lg_z, lg_v, lg_c);
   end

   // ======================================================================
   // outputs and flag mask
   // ======================================================================

   assign use_adder = ctl.op inside {[OP_ADD:OP_CMP]};

   assign result = use_adder ? ((ctl.op == OP_CMP) ? '0 : sum16) : lg_res;
   assign flags  = use_adder ? add_flags : lg_flags;

   always_comb begin
      case (ctl.op)
         OP_NOP, OP_INC2, OP_DEC2:                       ccmask = 4'b0000;
         OP_SXT:                                         ccmask = 4'b0100;
         OP_INC, OP_DEC, OP_MOV, OP_BIT, OP_BIC, OP_BIS: ccmask = 4'b1110;
         OP_EXOR:                                        ccmask = 4'b1100;
         default:                                        ccmask = 4'b1111;
      endcase
   end

   // unused encodings write nothing
   assign touches_cc = ctl.op inside {[OP_ADD:OP_DEC], [OP_NEG:OP_SWAB]};
   assign wmask      = touches_cc ? ccmask : '0;

   always_comb begin
      if (!$isunknown(ctl.op)) begin
         if (!$isunknown({ctl.byte_mode, ctl.src, ctl.dst, ctl.ci, ctl.ni})) begin
            a_out_known: assert final (!$isunknown({result, flags, wmask}))
               else $error("lsi_alu: outputs unknown for op %0d", ctl.op);
         end
      end
   end

endmodule

// File: cc_register.sv
`timescale 1ns/1ps

module cc_register (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         update,
   input  pdp_pkg::cc_t flags,
   input  pdp_pkg::cc_t wmask,
   input  logic         load,
   input  pdp_pkg::cc_t load_data,
   output pdp_pkg::cc_t cc
);
   import pdp_pkg::*;

   cc_t merged;   // alu flags under the mask, old bits elsewhere

   assign merged = (cc & ~wmask) | (flags & wmask);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cc <= '0;
      end else if (load) begin
         cc <= load_data;
      end else if (update) begin
         cc <= merged;
      end
   end

   // ======================================================================
   // checks
   // ======================================================================

   // a direct load and an alu op never share a cycle
   a_no_load_update: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(load && update)
   ) else $error("cc_register: load and update high together");

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             in_valid,
   input  pdp_pkg::alu_op_e op,
   input  logic             byte_mode,
   input  pdp_pkg::word_t   src,
   input  pdp_pkg::word_t   dst,
   input  logic             psw_load,
   input  pdp_pkg::cc_t     psw_data,
   output logic             out_valid,
   output pdp_pkg::word_t   result,
   output pdp_pkg::cc_t     psw
);
   import pdp_pkg::*;

   word_t alu_result;
   cc_t   alu_flags;
   cc_t   alu_wmask;

   alu_ctl_if ctl ();

   // ======================================================================
   // alu control, straight from the inputs
   // ======================================================================

   assign ctl.op        = in_valid ? op : OP_NOP;   // idle cycles run a nop
   assign ctl.byte_mode = byte_mode;
   assign ctl.src       = src;
   assign ctl.dst       = dst;
   assign ctl.ci        = psw[CC_C];
   assign ctl.ni        = psw[CC_N];

   lsi_alu u_alu (
      .ctl    (ctl),
      .result (alu_result),
      .flags  (alu_flags),
      .wmask  (alu_wmask)
   );

   // flags land on the same edge as the result
   cc_register u_cc (
      .clk       (clk),
      .arst_n    (arst_n),
      .update    (in_valid),
      .flags     (alu_flags),
      .wmask     (alu_wmask),
      .load      (psw_load),
      .load_data (psw_data),
      .cc        (psw)
   );

   // ======================================================================
   // result register
   // ======================================================================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         result    <= '0;
      end else begin
         out_valid <= in_valid;
         if (in_valid) begin
            result <= alu_result;   // holds while idle
         end
      end
   end

endmodule

// File: tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
   import pdp_pkg::*;

   localparam int   CLK_PERIOD = 20;
   localparam int   N_RAND     = 200;
   localparam int   SEED       = 6;
   localparam logic WRD        = 1'b0;
   localparam logic BYT        = 1'b1;

   typedef struct packed {
      alu_op_e op;
      logic    bm;
      word_t   src;
      word_t   dst;
      logic    ld;        // psw load cycle ahead of the op
      cc_t     ld_val;
      word_t   exp_res;
      cc_t     exp_psw;
   } vec_t;

   logic    clk;
   logic    arst_n;
   logic    in_valid;
   alu_op_e op;
   logic    byte_mode;
   word_t   src;
   word_t   dst;
   logic    psw_load;
   cc_t     psw_data;
   logic    out_valid;
   word_t   result;
   cc_t     psw;

   vec_t    tbl[$];
   logic    pend_ld;
   cc_t     pend_val;
   logic    tbl_ready;
   string   where;

   exec_unit UUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .op        (op),
      .byte_mode (byte_mode),
      .src       (src),
      .dst       (dst),
      .psw_load  (psw_load),
      .psw_data  (psw_data),
      .out_valid (out_valid),
      .result    (result),
      .psw       (psw)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ======================================================================
   // checks
   // ======================================================================

   task automatic fail_run(input string why);
      $display("Test FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("error: %s expected %h got %h at %s", name, exp, act, where);
         fail_run("result word mismatch");
      end
   endtask

   task automatic check_cc(input string name, input cc_t exp, input cc_t act);
      if (act !== exp) begin
         $display("error: %s expected %h got %h at %s", name, exp, act, where);
         fail_run("condition code mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error: %s expected %h got %h at %s", name, exp, act, where);
         fail_run("strobe mismatch");
      end
   endtask

   // two's complement add, or dst minus src with borrow in C
   task automatic model_add_sub(input logic is_sub, input word_t s, input word_t d,
                                output word_t r, output cc_t f);
      logic [WORD_W:0] wide;
      f = 4'b0000;
      if (is_sub) begin
         wide    = {1'b0, d} - {1'b0, s};
         r       = wide[WORD_W-1:0];
         f[CC_C] = (s > d);
         f[CC_V] = (s[15] != d[15]) && (r[15] != d[15]);
      end else begin
         wide    = {1'b0, s} + {1'b0, d};
         r       = wide[WORD_W-1:0];
         f[CC_C] = wide[WORD_W];
         f[CC_V] = (s[15] == d[15]) && (r[15] != s[15]);
      end
      f[CC_N] = r[15];
      f[CC_Z] = (r == 16'h0000);
   endtask

   // ======================================================================
   // stimulus table
   // ======================================================================

   task automatic preload_next(input cc_t val);
      pend_ld  = 1'b1;
      pend_val = val;
   endtask

   task automatic add_vec(input alu_op_e v_op, input logic v_bm, input word_t v_src,
                          input word_t v_dst, input word_t v_res, input cc_t v_psw);
      vec_t v;
      v.op      = v_op;
      v.bm      = v_bm;
      v.src     = v_src;
      v.dst     = v_dst;
      v.ld      = pend_ld;
      v.ld_val  = pend_ld ? pend_val : 4'b0000;
      v.exp_res = v_res;
      v.exp_psw = v_psw;
      tbl.push_back(v);
      pend_ld = 1'b0;
   endtask

   // expected psw follows on from the entry before, NZVC
   task automatic build_table();
      pend_ld = 1'b0;
      // arithmetic
      add_vec(OP_ADD,  WRD, 16'h7fff, 16'h0001, 16'h8000, 4'b1010);
      add_vec(OP_ADD,  WRD, 16'hffff, 16'h0001, 16'h0000, 4'b0101);
      add_vec(OP_ADC,  WRD, 16'h0000, 16'h1234, 16'h1235, 4'b0000);
      add_vec(OP_SUB,  WRD, 16'h0001, 16'h0000, 16'hffff, 4'b1001);
      add_vec(OP_SUB,  WRD, 16'h0001, 16'h8000, 16'h7fff, 4'b0010);
      add_vec(OP_SBC,  WRD, 16'h0000, 16'h0005, 16'h0005, 4'b0000);
      add_vec(OP_INC,  WRD, 16'h0000, 16'h7fff, 16'h8000, 4'b1010);
      add_vec(OP_DEC,  WRD, 16'h0000, 16'h8000, 16'h7fff, 4'b0010);
      add_vec(OP_INC,  BYT, 16'h0000, 16'h007f, 16'h0080, 4'b1010);
      add_vec(OP_DEC,  BYT, 16'h0000, 16'h0080, 16'h007f, 4'b0010);
      add_vec(OP_NEG,  WRD, 16'h0000, 16'h0001, 16'hffff, 4'b1001);
      add_vec(OP_NEG,  WRD, 16'h0000, 16'h8000, 16'h8000, 4'b1011);
      add_vec(OP_NEG,  BYT, 16'h0000, 16'h0080, 16'hff80, 4'b1011);
      add_vec(OP_CMP,  WRD, 16'h0005, 16'h0003, 16'h0000, 4'b1001);
      add_vec(OP_CMP,  WRD, 16'h1234, 16'h1234, 16'h0000, 4'b0100);
      add_vec(OP_CMP,  BYT, 16'h0001, 16'h0080, 16'h0000, 4'b0010);
      // logic and shifts
      add_vec(OP_CLR,  WRD, 16'h0000, 16'h1234, 16'h0000, 4'b0100);
      add_vec(OP_COM,  WRD, 16'h0000, 16'h00ff, 16'hff00, 4'b1001);
      add_vec(OP_COM,  BYT, 16'h0000, 16'h00ff, 16'hff00, 4'b0101);
      add_vec(OP_TST,  WRD, 16'h0000, 16'h8000, 16'h0000, 4'b1000);
      add_vec(OP_ASR,  WRD, 16'h0000, 16'h8001, 16'hc000, 4'b1001);
      add_vec(OP_ASR,  BYT, 16'h0000, 16'h0081, 16'h00c0, 4'b1001);
      add_vec(OP_ASL,  WRD, 16'h0000, 16'h4000, 16'h8000, 4'b1010);
      add_vec(OP_ASL,  BYT, 16'h0000, 16'h0080, 16'h0000, 4'b0111);
      add_vec(OP_ROR,  WRD, 16'h0000, 16'h0001, 16'h8000, 4'b1001);
      add_vec(OP_ROL,  WRD, 16'h0000, 16'h0001, 16'h0003, 4'b0000);
      add_vec(OP_SXT,  WRD, 16'h0000, 16'h0000, 16'h0000, 4'b0100);
      add_vec(OP_MOV,  BYT, 16'h0000, 16'h1280, 16'hff80, 4'b1000);
      add_vec(OP_BIT,  WRD, 16'h00f0, 16'h0f0f, 16'h0000, 4'b0100);
      add_vec(OP_BIC,  WRD, 16'hffff, 16'h00f0, 16'hff0f, 4'b1000);
      add_vec(OP_BIS,  WRD, 16'h0f00, 16'h00f0, 16'h0ff0, 4'b0000);
      add_vec(OP_EXOR, WRD, 16'h8001, 16'h0001, 16'h8000, 4'b1000);
      add_vec(OP_EXOR, BYT, 16'h00ff, 16'h00ff, 16'h0000, 4'b0100);
      add_vec(OP_SWAB, WRD, 16'h0000, 16'h1280, 16'h8012, 4'b0000);
      // flag masking
      preload_next(4'b1111);
      add_vec(OP_INC2, WRD, 16'h0000, 16'h0010, 16'h0012, 4'b1111);
      add_vec(OP_DEC2, WRD, 16'h0000, 16'h0010, 16'h000e, 4'b1111);
      add_vec(OP_INC,  WRD, 16'h0000, 16'h0001, 16'h0002, 4'b0001);
      preload_next(4'b1111);
      add_vec(OP_DEC,  WRD, 16'h0000, 16'h0002, 16'h0001, 4'b0001);
      preload_next(4'b1111);
      add_vec(OP_MOV,  WRD, 16'h0000, 16'h0001, 16'h0001, 4'b0001);
      add_vec(OP_BIT,  WRD, 16'h0001, 16'h0001, 16'h0000, 4'b0001);
      add_vec(OP_BIC,  WRD, 16'h00ff, 16'h000f, 16'h00f0, 4'b0001);
      add_vec(OP_BIS,  WRD, 16'h0000, 16'h0000, 16'h0000, 4'b0101);
      preload_next(4'b1111);
      add_vec(OP_EXOR, WRD, 16'h0001, 16'h0001, 16'h0000, 4'b0111);
      preload_next(4'b1111);
      add_vec(OP_SXT,  WRD, 16'h0000, 16'h0000, 16'hffff, 4'b1011);
      // carry chain, back to back
      add_vec(OP_ADD,  WRD, 16'hffff, 16'h0002, 16'h0001, 4'b0001);
      add_vec(OP_ADC,  WRD, 16'h0000, 16'hffff, 16'h0000, 4'b0101);
      add_vec(OP_SBC,  WRD, 16'h0000, 16'h0000, 16'hffff, 4'b1001);
      add_vec(OP_ROR,  WRD, 16'h0000, 16'h0002, 16'h8001, 4'b1010);
      add_vec(OP_ROL,  WRD, 16'h0000, 16'h8000, 16'h0000, 4'b0111);
      add_vec(OP_ROR,  BYT, 16'h0000, 16'h0000, 16'h0080, 4'b1010);
      add_vec(OP_ROL,  BYT, 16'h0000, 16'h0080, 16'h0000, 4'b0111);
      add_vec(OP_ADC,  BYT, 16'h0000, 16'h00ff, 16'h0100, 4'b0101);
      add_vec(OP_SBC,  BYT, 16'h0000, 16'h0080, 16'h007f, 4'b0010);
   endtask

   // ======================================================================
   // main sequence
   // ======================================================================

   initial begin : watchdog
      int n_cycles;
      wait (tbl_ready === 1'b1);
      n_cycles = tbl.size() + N_RAND + 20;
      #(n_cycles * CLK_PERIOD);
      fail_run($sformatf("run timed out after %0d clock cycles", n_cycles));
   end

   initial begin : stimulus
      logic [31:0] rnd;
      word_t       exp_res;
      cc_t         exp_psw;
      word_t       r_src;
      word_t       r_dst;
      logic        r_sub;

      arst_n    = 1'b0;
      in_valid  = 1'b0;
      op        = OP_NOP;
      byte_mode = 1'b0;
      src       = 16'h0000;
      dst       = 16'h0000;
      psw_load  = 1'b0;
      psw_data  = 4'b0000;
      tbl_ready = 1'b0;
      where     = "reset";
      rnd       = $urandom(SEED);

      build_table();
      tbl_ready = 1'b1;

      repeat (3) begin
         @(posedge clk);
         #1;
         check_bit("out_valid", 1'b0, out_valid);
         check_word("result", 16'h0000, result);
         check_cc("psw", 4'b0000, psw);
      end
      #1 arst_n = 1'b1;
      @(posedge clk);
      #1;
      where = "after reset";
      check_bit("out_valid", 1'b0, out_valid);
      check_word("result", 16'h0000, result);
      check_cc("psw", 4'b0000, psw);
      #1;

      for (int i = 0; i < tbl.size(); i++) begin
         where = $sformatf("table entry %0d", i);
         if (tbl[i].ld) begin
            in_valid = 1'b0;
            psw_load = 1'b1;
            psw_data = tbl[i].ld_val;
            @(posedge clk);
            #1;
            check_bit("out_valid", 1'b0, out_valid);
            check_cc("psw", tbl[i].ld_val, psw);
            #1 psw_load = 1'b0;
         end
         in_valid  = 1'b1;
         op        = tbl[i].op;
         byte_mode = tbl[i].bm;
         src       = tbl[i].src;
         dst       = tbl[i].dst;
         @(posedge clk);
         #1;
         check_bit("out_valid", 1'b1, out_valid);
         check_word("result", tbl[i].exp_res, result);
         check_cc("psw", tbl[i].exp_psw, psw);
         #1;
      end

      // one idle cycle, everything holds
      in_valid = 1'b0;
      op       = OP_COM;   // a live op that must be ignored
      where    = "idle cycle";
      @(posedge clk);
      #1;
      check_bit("out_valid", 1'b0, out_valid);
      check_word("result", tbl[tbl.size()-1].exp_res, result);
      check_cc("psw", tbl[tbl.size()-1].exp_psw, psw);
      #1;

      for (int k = 0; k < N_RAND; k++) begin
         rnd   = $urandom();
         r_src = rnd[15:0];
         r_dst = rnd[31:16];
         rnd   = $urandom();
         r_sub = rnd[0];
         model_add_sub(r_sub, r_src, r_dst, exp_res, exp_psw);
         where     = $sformatf("random op %0d", k);
         in_valid  = 1'b1;
         op        = r_sub ? OP_SUB : OP_ADD;
         byte_mode = 1'b0;
         src       = r_src;
         dst       = r_dst;
         @(posedge clk);
         #1;
         check_bit("out_valid", 1'b1, out_valid);
         check_word("result", exp_res, result);
         check_cc("psw", exp_psw, psw);
         #1;
      end

      in_valid = 1'b0;
      where    = "end of run";
      @(posedge clk);
      #1;
      check_bit("out_valid", 1'b0, out_valid);

      $display("Test OK");
      $finish;
   end

endmodule

// File: sources.f
pdp_pkg.sv
alu_ctl_if.sv
alu_adder.sv
lsi_alu.sv
cc_register.sv
exec_unit.sv
tb_exec_unit.sv

// File: run.sh
#!/bin/sh
# build and run the exec_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exec_unit -f sources.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vtb_exec_unit
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
